// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_tk_ctrl \
  -f sim.f

./obj_dir/Vtb_tk_ctrl

// ==== sim.f ====
+incdir+src
src/tk_bus_pkg.sv
src/tk_map_pkg.sv
src/apb_if.sv
src/apb_interconnect.sv
src/sys_ctrl_regs.sv
src/secret_store.sv
src/tk_ctrl_top.sv
test/tb_tk_ctrl.sv

// ==== src/apb_if.sv ====
`default_nettype none

interface apb_if
  import tk_bus_pkg::*;
();

  // Request side
  addr_t paddr;
  logic  pwrite;
  data_t pwdata;
  logic  psel;
  logic  penable;

  // Completion side
  data_t prdata;
  logic  pready;
  logic  pslverr;

  // Bus master or interconnect output port
  modport requester (
    output paddr, pwrite, pwdata, psel, penable,
    input  prdata, pready, pslverr
  );

  // Slave or interconnect input port
  modport completer (
    input  paddr, pwrite, pwdata, psel, penable,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

// ==== src/apb_interconnect.sv ====
`default_nettype none

module apb_interconnect
  import tk_bus_pkg::*, tk_map_pkg::*;
(
  input  wire      clk,
  input  wire      reset_n,
  apb_if.completer m0,
  apb_if.completer m1,
  apb_if.requester ctrl_bus,
  apb_if.requester secret_bus
);

  grant_e  grant_q;
  grant_e  arb_grant;
  grant_e  sel;
  logic    last_m1_q;
  logic    use_m1;

  addr_t   req_paddr;
  logic    req_pwrite;
  data_t   req_pwdata;
  logic    req_psel;
  logic    req_penable;
  region_e region;

  data_t   rsp_rdata;
  logic    rsp_ready;
  resp_e   rsp_resp;

  // --------------------
  // Arbitration
  // --------------------

  // Round robin only matters when both ask in the same idle cycle
  always_comb begin
    if (m0.psel && m1.psel) begin
      arb_grant = last_m1_q ? GRANT_M0 : GRANT_M1;
    end else if (m0.psel) begin
      arb_grant = GRANT_M0;
    end else if (m1.psel) begin
      arb_grant = GRANT_M1;
    end else begin
      arb_grant = GRANT_IDLE;
    end
  end

  // First cycle of a grant acts as the slave's setup phase
  assign sel    = (grant_q == GRANT_IDLE) ? arb_grant : grant_q;
  assign use_m1 = (sel == GRANT_M1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      grant_q   <= GRANT_IDLE;
      last_m1_q <= 1'b0;
    end else if (grant_q == GRANT_IDLE) begin
      grant_q <= arb_grant;
      if (arb_grant != GRANT_IDLE) begin
        last_m1_q <= (arb_grant == GRANT_M1);
      end
    end else if (rsp_ready) begin
      grant_q <= GRANT_IDLE;
    end
  end

  // --------------------
  // Request path
  // --------------------
  assign req_paddr   = use_m1 ? m1.paddr : m0.paddr;
  assign req_pwrite  = use_m1 ? m1.pwrite : m0.pwrite;
  assign req_pwdata  = use_m1 ? m1.pwdata : m0.pwdata;
  assign req_psel    = ((sel == GRANT_M0) & m0.psel) | ((sel == GRANT_M1) & m1.psel);
  // A waiting master already has penable up so it is held back one cycle
  assign req_penable = (grant_q != GRANT_IDLE) & (use_m1 ? m1.penable : m0.penable);
  assign region      = decode_region(req_paddr);

  assign ctrl_bus.paddr   = req_paddr;
  assign ctrl_bus.pwrite  = req_pwrite;
  assign ctrl_bus.pwdata  = req_pwdata;
  assign ctrl_bus.psel    = req_psel & (region == REGION_CTRL);
  assign ctrl_bus.penable = req_penable;

  assign secret_bus.paddr   = req_paddr;
  assign secret_bus.pwrite  = req_pwrite;
  assign secret_bus.pwdata  = req_pwdata;
  assign secret_bus.psel    = req_psel & (region == REGION_SECRET);
  assign secret_bus.penable = req_penable;

  // --------------------
  // Response path
  // --------------------
  always_comb begin
    rsp_rdata = '0;
    rsp_ready = 1'b0;
    rsp_resp  = RESP_OKAY;
    case (region)
      REGION_CTRL: begin
        rsp_rdata = ctrl_bus.prdata;
        rsp_ready = ctrl_bus.pready;
        rsp_resp  = ctrl_bus.pslverr ? RESP_ERROR : RESP_OKAY;
      end
      REGION_SECRET: begin
        rsp_rdata = secret_bus.prdata;
        rsp_ready = secret_bus.pready;
        rsp_resp  = secret_bus.pslverr ? RESP_ERROR : RESP_OKAY;
      end
      default: begin
        // Unmapped addresses are answered here
        rsp_ready = req_psel & req_penable;
        rsp_resp  = RESP_ERROR;
      end
    endcase
  end

  assign m0.prdata  = (sel == GRANT_M0) ? rsp_rdata : '0;
  assign m0.pready  = (sel == GRANT_M0) & rsp_ready;
  assign m0.pslverr = (sel == GRANT_M0) & rsp_ready & (rsp_resp == RESP_ERROR);

  assign m1.prdata  = (sel == GRANT_M1) ? rsp_rdata : '0;
  assign m1.pready  = (sel == GRANT_M1) & rsp_ready;
  assign m1.pslverr = (sel == GRANT_M1) & rsp_ready & (rsp_resp == RESP_ERROR);

  // Masters must not abandon a granted transfer
  a_m0_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (sel == GRANT_M0 && m0.psel && !m0.pready) |=> m0.psel);
  a_m1_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (sel == GRANT_M1 && m1.psel && !m1.pready) |=> m1.psel);

endmodule

`default_nettype wire

// ==== src/secret_store.sv ====
`default_nettype none
`include "tk_settings.svh"

module secret_store
  import tk_bus_pkg::*, tk_map_pkg::*;
(
  input  wire      clk,
  input  wire      reset_n,
  apb_if.completer bus,
  input  wire      app_mode
);

  localparam int CDI_WORDS = 8;

  data_t                          cdi_q [CDI_WORDS];
  logic                           access;
  logic                           in_cdi;
  logic                           in_udi;
  logic                           cdi_we;
  logic [$clog2(CDI_WORDS)-1:0]   cdi_idx;
  data_t                          udi_word;
  data_t                          rdata;
  resp_e                          resp;

  assign access   = bus.psel & bus.penable;
  assign in_cdi   = (bus.paddr >= CDI_FIRST) && (bus.paddr <= CDI_LAST);
  assign in_udi   = (bus.paddr >= UDI_FIRST) && (bus.paddr <= UDI_LAST);
  assign cdi_idx  = bus.paddr[$clog2(CDI_WORDS)-1:0];
  assign udi_word = bus.paddr[0] ? `TK_UDI1 : `TK_UDI0;

  // --------------------
  // Access rules
  // --------------------
  always_comb begin
    rdata  = '0;
    resp   = RESP_OKAY;
    cdi_we = 1'b0;
    if (in_cdi) begin
      rdata = cdi_q[cdi_idx];
      if (bus.pwrite) begin
        if (app_mode) begin
          resp = RESP_ERROR;
        end else begin
          cdi_we = access;
        end
      end
    end else if (in_udi) begin
      // UDI is read only and hidden from the application
      if (bus.pwrite || app_mode) begin
        resp = RESP_ERROR;
      end else begin
        rdata = udi_word;
      end
    end else begin
      resp = RESP_ERROR;
    end
  end

  assign bus.prdata  = rdata;
  assign bus.pready  = access;
  assign bus.pslverr = access & (resp == RESP_ERROR);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < CDI_WORDS; i++) begin
        cdi_q[i] <= '0;
      end
    end else if (cdi_we) begin
      cdi_q[cdi_idx] <= bus.pwdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/sys_ctrl_regs.sv ====
`default_nettype none
`include "tk_settings.svh"

module sys_ctrl_regs
  import tk_bus_pkg::*, tk_map_pkg::*;
(
  input  wire      clk,
  input  wire      reset_n,
  apb_if.completer bus,
  input  wire      gpio1,
  input  wire      gpio2,
  output logic     gpio3,
  output logic     gpio4,
  output logic     led_r,
  output logic     led_g,
  output logic     led_b,
  output logic     app_mode
);

  logic       app_mode_q;
  logic [2:0] led_q;
  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;
  logic       gpio3_q;
  logic       gpio4_q;
  data_t      app_start_q;
  data_t      app_size_q;
  data_t      hash_addr_q;

  logic       access;
  logic       wr;
  logic       switch_we;
  logic       led_we;
  logic       gpio_we;
  logic       app_start_we;
  logic       app_size_we;
  logic       hash_addr_we;
  logic       bad;
  logic [3:0] gpio_rd;
  data_t      rdata;
  resp_e      resp;

  assign access = bus.psel & bus.penable;
  assign wr     = access & bus.pwrite;

  always_comb begin
    gpio_rd            = '0;
    gpio_rd[GPIO1_BIT] = gpio1_sync[1];
    gpio_rd[GPIO2_BIT] = gpio2_sync[1];
    gpio_rd[GPIO3_BIT] = gpio3_q;
    gpio_rd[GPIO4_BIT] = gpio4_q;
  end

  // --------------------
  // Register decode
  // --------------------
  always_comb begin
    switch_we    = 1'b0;
    led_we       = 1'b0;
    gpio_we      = 1'b0;
    app_start_we = 1'b0;
    app_size_we  = 1'b0;
    hash_addr_we = 1'b0;
    bad          = 1'b0;
    rdata        = '0;
    case (bus.paddr)
      CTRL_NAME0: begin
        rdata = `TK_NAME0;
        bad   = bus.pwrite;
      end
      CTRL_NAME1: begin
        rdata = `TK_NAME1;
        bad   = bus.pwrite;
      end
      CTRL_VERSION: begin
        rdata = `TK_VERSION;
        bad   = bus.pwrite;
      end
      CTRL_SWITCH_APP: begin
        rdata     = {`TK_DATA_W{app_mode_q}};
        switch_we = wr;
      end
      CTRL_LED: begin
        rdata  = data_t'(led_q);
        led_we = wr;
      end
      CTRL_GPIO: begin
        rdata   = data_t'(gpio_rd);
        gpio_we = wr;
      end
      // Application region is frozen once the app runs
      CTRL_APP_START: begin
        rdata        = app_start_q;
        app_start_we = wr & !app_mode_q;
        bad          = bus.pwrite & app_mode_q;
      end
      CTRL_APP_SIZE: begin
        rdata       = app_size_q;
        app_size_we = wr & !app_mode_q;
        bad         = bus.pwrite & app_mode_q;
      end
      CTRL_HASH_ADDR: begin
        rdata        = hash_addr_q;
        hash_addr_we = wr & !app_mode_q;
        bad          = bus.pwrite & app_mode_q;
      end
      default: bad = 1'b1;
    endcase
    resp = bad ? RESP_ERROR : RESP_OKAY;
  end

  assign bus.prdata  = rdata;
  assign bus.pready  = access;
  assign bus.pslverr = access & (resp == RESP_ERROR);

  // --------------------
  // Register update
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode_q  <= 1'b0;
      led_q       <= `TK_LED_RESET;
      gpio1_sync  <= '0;
      gpio2_sync  <= '0;
      gpio3_q     <= 1'b0;
      gpio4_q     <= 1'b0;
      app_start_q <= '0;
      app_size_q  <= '0;
      hash_addr_q <= '0;
    end else begin
      // Two flop synchronizers for the pins
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};
      if (switch_we) begin
        app_mode_q <= 1'b1;
      end
      if (led_we) begin
        led_q[LED_R_BIT] <= bus.pwdata[LED_R_BIT];
        led_q[LED_G_BIT] <= bus.pwdata[LED_G_BIT];
        led_q[LED_B_BIT] <= bus.pwdata[LED_B_BIT];
      end
      if (gpio_we) begin
        gpio3_q <= bus.pwdata[GPIO3_BIT];
        gpio4_q <= bus.pwdata[GPIO4_BIT];
      end
      if (app_start_we) begin
        app_start_q <= bus.pwdata;
      end
      if (app_size_we) begin
        app_size_q <= bus.pwdata;
      end
      if (hash_addr_we) begin
        hash_addr_q <= bus.pwdata;
      end
    end
  end

  assign gpio3    = gpio3_q;
  assign gpio4    = gpio4_q;
  assign led_r    = led_q[LED_R_BIT];
  assign led_g    = led_q[LED_G_BIT];
  assign led_b    = led_q[LED_B_BIT];
  assign app_mode = app_mode_q;

  // Every access phase follows its own setup phase
  a_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
    (bus.psel && bus.penable) |-> $past(bus.psel && !bus.penable));

endmodule

`default_nettype wire

// ==== src/tk_bus_pkg.sv ====
`default_nettype none
`include "tk_settings.svh"

package tk_bus_pkg;

  // --------------------
  // Bus word types
  // --------------------
  typedef logic [`TK_ADDR_W-1:0] addr_t;
  typedef logic [`TK_DATA_W-1:0] data_t;

  // Owner of the shared bus
  typedef enum logic [1:0] {
    GRANT_IDLE = 2'd0,
    GRANT_M0   = 2'd1,
    GRANT_M1   = 2'd2
  } grant_e;

  // Completion status, maps straight onto pslverr
  typedef enum logic {
    RESP_OKAY  = 1'b0,
    RESP_ERROR = 1'b1
  } resp_e;

endpackage

`default_nettype wire

// ==== src/tk_ctrl_top.sv ====
`default_nettype none
`include "tk_settings.svh"

module tk_ctrl_top (
  input  wire                   clk,
  input  wire                   reset_n,
  // CPU port
  input  wire  [`TK_ADDR_W-1:0] m0_paddr,
  input  wire                   m0_pwrite,
  input  wire  [`TK_DATA_W-1:0] m0_pwdata,
  input  wire                   m0_psel,
  input  wire                   m0_penable,
  output logic [`TK_DATA_W-1:0] m0_prdata,
  output logic                  m0_pready,
  output logic                  m0_pslverr,
  // Debug and provisioning port
  input  wire  [`TK_ADDR_W-1:0] m1_paddr,
  input  wire                   m1_pwrite,
  input  wire  [`TK_DATA_W-1:0] m1_pwdata,
  input  wire                   m1_psel,
  input  wire                   m1_penable,
  output logic [`TK_DATA_W-1:0] m1_prdata,
  output logic                  m1_pready,
  output logic                  m1_pslverr,
  // Pins
  input  wire                   gpio1,
  input  wire                   gpio2,
  output logic                  gpio3,
  output logic                  gpio4,
  output logic                  led_r,
  output logic                  led_g,
  output logic                  led_b,
  output logic                  fw_app_mode
);

  apb_if m0_bus ();
  apb_if m1_bus ();
  apb_if ctrl_bus ();
  apb_if secret_bus ();

  logic app_mode;

  // --------------------
  // Master ports
  // --------------------
  assign m0_bus.paddr   = m0_paddr;
  assign m0_bus.pwrite  = m0_pwrite;
  assign m0_bus.pwdata  = m0_pwdata;
  assign m0_bus.psel    = m0_psel;
  assign m0_bus.penable = m0_penable;
  assign m0_prdata      = m0_bus.prdata;
  assign m0_pready      = m0_bus.pready;
  assign m0_pslverr     = m0_bus.pslverr;

  assign m1_bus.paddr   = m1_paddr;
  assign m1_bus.pwrite  = m1_pwrite;
  assign m1_bus.pwdata  = m1_pwdata;
  assign m1_bus.psel    = m1_psel;
  assign m1_bus.penable = m1_penable;
  assign m1_prdata      = m1_bus.prdata;
  assign m1_pready      = m1_bus.pready;
  assign m1_pslverr     = m1_bus.pslverr;

  apb_interconnect u_apb_interconnect (
    .clk        (clk),
    .reset_n    (reset_n),
    .m0         (m0_bus),
    .m1         (m1_bus),
    .ctrl_bus   (ctrl_bus),
    .secret_bus (secret_bus)
  );

  sys_ctrl_regs u_sys_ctrl_regs (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus      (ctrl_bus),
    .gpio1    (gpio1),
    .gpio2    (gpio2),
    .gpio3    (gpio3),
    .gpio4    (gpio4),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b),
    .app_mode (app_mode)
  );

  secret_store u_secret_store (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus      (secret_bus),
    .app_mode (app_mode)
  );

  assign fw_app_mode = app_mode;

endmodule

`default_nettype wire

// ==== src/tk_map_pkg.sv ====
`default_nettype none
`include "tk_settings.svh"

package tk_map_pkg;

  // --------------------
  // Address regions
  // --------------------
  typedef enum logic [1:0] {
    REGION_CTRL   = 2'd0,
    REGION_SECRET = 2'd1,
    REGION_NONE   = 2'd2
  } region_e;

  localparam logic [`TK_ADDR_W-1:0] CTRL_LAST   = 8'h1f;
  localparam logic [`TK_ADDR_W-1:0] SECRET_LAST = 8'h3f;

  // Control block offsets
  typedef enum logic [`TK_ADDR_W-1:0] {
    CTRL_NAME0      = 8'h00,
    CTRL_NAME1      = 8'h01,
    CTRL_VERSION    = 8'h02,
    CTRL_SWITCH_APP = 8'h08,
    CTRL_LED        = 8'h09,
    CTRL_GPIO       = 8'h0a,
    CTRL_APP_START  = 8'h0c,
    CTRL_APP_SIZE   = 8'h0d,
    CTRL_HASH_ADDR  = 8'h10
  } ctrl_reg_e;

  // Secret store layout
  localparam logic [`TK_ADDR_W-1:0] CDI_FIRST = 8'h20;
  localparam logic [`TK_ADDR_W-1:0] CDI_LAST  = 8'h27;
  localparam logic [`TK_ADDR_W-1:0] UDI_FIRST = 8'h30;
  localparam logic [`TK_ADDR_W-1:0] UDI_LAST  = 8'h31;

  // --------------------
  // Field bit positions
  // --------------------
  localparam int LED_R_BIT = 2;
  localparam int LED_G_BIT = 1;
  localparam int LED_B_BIT = 0;

  localparam int GPIO1_BIT = 0;
  localparam int GPIO2_BIT = 1;
  localparam int GPIO3_BIT = 2;
  localparam int GPIO4_BIT = 3;

  function automatic region_e decode_region(logic [`TK_ADDR_W-1:0] addr);
    region_e region;
    if (addr <= CTRL_LAST) begin
      region = REGION_CTRL;
    end else if (addr <= SECRET_LAST) begin
      region = REGION_SECRET;
    end else begin
      region = REGION_NONE;
    end
    return region;
  endfunction

endpackage

`default_nettype wire

// ==== src/tk_settings.svh ====
`ifndef TK_SETTINGS_SVH
`define TK_SETTINGS_SVH

// Bus widths
`define TK_ADDR_W 8
`define TK_DATA_W 32

// Identity words
// "tk1 " and "ctrl" in ASCII
`define TK_NAME0   32'h746b3120
`define TK_NAME1   32'h6374726c
`define TK_VERSION 32'h00000004

// Unique device identity
`define TK_UDI0 32'h0f1e2d3c
`define TK_UDI1 32'h4b5a6978

// LED state out of reset, red and green lit
`define TK_LED_RESET 3'b110

`endif

// ==== test/tb_tk_ctrl.sv ====
`default_nettype none
`include "tk_settings.svh"

module tb_tk_ctrl
  import tk_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_OPS       = 40;
  localparam int DIRECTED_XFERS = 60;
  localparam int PLANNED_XFERS  = DIRECTED_XFERS + 4 * RAND_OPS;

  typedef struct packed {
    logic [7:0]  addr;
    logic        write;
    logic [32:0] got;
    logic [32:0] exp;
  } done_t;

  logic        clk;
  logic        reset_n;
  logic [7:0]  m0_paddr;
  logic        m0_pwrite;
  logic [31:0] m0_pwdata;
  logic        m0_psel;
  logic        m0_penable;
  logic [31:0] m0_prdata;
  logic        m0_pready;
  logic        m0_pslverr;
  logic [7:0]  m1_paddr;
  logic        m1_pwrite;
  logic [31:0] m1_pwdata;
  logic        m1_psel;
  logic        m1_penable;
  logic [31:0] m1_prdata;
  logic        m1_pready;
  logic        m1_pslverr;
  logic        gpio1;
  logic        gpio2;
  logic        gpio3;
  logic        gpio4;
  logic        led_r;
  logic        led_g;
  logic        led_b;
  logic        fw_app_mode;

  // Reference model of the register map
  logic [31:0] model_regs [0:255];
  logic        app_mode_m;
  done_t       done_q [$];

  tk_ctrl_top u_tk_ctrl_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Reference model
  // --------------------

  // Expected {pslverr, prdata} of one transfer in the current mode
  function automatic logic [32:0] expect_xfer(input logic [7:0] addr, input logic write);
    logic [32:0] r;
    r = {1'b1, 32'h0};
    if (addr inside {CTRL_NAME0, CTRL_NAME1, CTRL_VERSION}) begin
      r = {write, model_regs[addr]};
    end else if (addr == CTRL_SWITCH_APP) begin
      r = {1'b0, {32{app_mode_m}}};
    end else if (addr inside {CTRL_LED, CTRL_GPIO}) begin
      r = {1'b0, model_regs[addr]};
    end else if (addr inside {CTRL_APP_START, CTRL_APP_SIZE, CTRL_HASH_ADDR} ||
                 (addr >= CDI_FIRST && addr <= CDI_LAST)) begin
      // Frozen once the application runs
      r = {write & app_mode_m, model_regs[addr]};
    end else if (addr >= UDI_FIRST && addr <= UDI_LAST) begin
      r = (write || app_mode_m) ? {1'b1, 32'h0} : {1'b0, model_regs[addr]};
    end
    return r;
  endfunction

  task automatic apply_write(input logic [7:0] addr, input logic [31:0] wdata);
    case (addr)
      CTRL_SWITCH_APP: app_mode_m = 1'b1;
      CTRL_LED:        model_regs[addr] = {29'h0, wdata[2:0]};
      // Input pin bits are not writable
      CTRL_GPIO:       model_regs[addr] = {28'h0, wdata[3:2], model_regs[addr][1:0]};
      default:         model_regs[addr] = wdata;
    endcase
  endtask

  task automatic log_completion(input logic [7:0] addr, input logic write,
                                input logic [31:0] wdata, input logic [31:0] rdata,
                                input logic err);
    done_t rec;
    rec.addr  = addr;
    rec.write = write;
    rec.got   = {err, rdata};
    rec.exp   = expect_xfer(addr, write);
    done_q.push_back(rec);
    if (write && !rec.exp[32]) begin
      apply_write(addr, wdata);
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "Stopping at first value error");
    end
  endtask

  // --------------------
  // APB masters
  // --------------------
  task automatic xfer_m0(input logic [7:0] addr, input logic write,
                         input logic [31:0] wdata, input logic solo);
    int cycles;
    @(posedge clk);
    m0_paddr   <= addr;
    m0_pwrite  <= write;
    m0_pwdata  <= wdata;
    m0_psel    <= 1'b1;
    m0_penable <= 1'b0;
    @(posedge clk);
    m0_penable <= 1'b1;
    cycles = 2;
    @(negedge clk);
    while (!m0_pready) begin
      cycles++;
      @(negedge clk);
    end
    log_completion(addr, write, wdata, m0_prdata, m0_pslverr);
    if (solo) begin
      compare_value("m0 transfer cycles", cycles, 32'd2);
    end
    @(posedge clk);
    m0_psel    <= 1'b0;
    m0_penable <= 1'b0;
  endtask

  task automatic xfer_m1(input logic [7:0] addr, input logic write,
                         input logic [31:0] wdata, input logic solo);
    int cycles;
    @(posedge clk);
    m1_paddr   <= addr;
    m1_pwrite  <= write;
    m1_pwdata  <= wdata;
    m1_psel    <= 1'b1;
    m1_penable <= 1'b0;
    @(posedge clk);
    m1_penable <= 1'b1;
    cycles = 2;
    @(negedge clk);
    while (!m1_pready) begin
      cycles++;
      @(negedge clk);
    end
    log_completion(addr, write, wdata, m1_prdata, m1_pslverr);
    if (solo) begin
      compare_value("m1 transfer cycles", cycles, 32'd2);
    end
    @(posedge clk);
    m1_psel    <= 1'b0;
    m1_penable <= 1'b0;
  endtask

  function automatic logic [7:0] pick_addr();
    logic [3:0] k;
    logic [7:0] a;
    k = 4'($urandom_range(0, 15));
    case (k)
      4'd8:    a = CTRL_LED;
      4'd9:    a = CTRL_GPIO;
      4'd10:   a = CTRL_APP_START;
      4'd11:   a = CTRL_APP_SIZE;
      4'd12:   a = CTRL_HASH_ADDR;
      4'd13:   a = UDI_FIRST + 8'($urandom_range(0, 1));
      4'd14:   a = CTRL_NAME1;
      4'd15:   a = 8'($urandom_range(8'h32, 8'hff));
      default: a = CDI_FIRST + {5'h0, k[2:0]};
    endcase
    return a;
  endfunction

  // Both masters at once, so the arbiter sees contention
  task automatic random_traffic(input int n);
    fork
      for (int i = 0; i < n; i++) begin
        xfer_m0(pick_addr(), 1'($urandom), $urandom, 1'b0);
        repeat ($urandom_range(0, 2)) @(posedge clk);
      end
      for (int i = 0; i < n; i++) begin
        xfer_m1(pick_addr(), 1'($urandom), $urandom, 1'b0);
        repeat ($urandom_range(0, 2)) @(posedge clk);
      end
    join
  endtask

  task automatic check_pins();
    @(negedge clk);
    compare_value("led_rgb", {29'h0, led_r, led_g, led_b}, {29'h0, model_regs[CTRL_LED][2:0]});
    compare_value("gpio4_gpio3", {30'h0, gpio4, gpio3}, {30'h0, model_regs[CTRL_GPIO][3:2]});
    compare_value("fw_app_mode", {31'h0, fw_app_mode}, {31'h0, app_mode_m});
  endtask

  // --------------------
  // Compare and watchdog
  // --------------------
  initial begin : compare_results
    done_t rec;
    forever begin
      @(posedge clk);
      while (done_q.size() > 0) begin
        rec = done_q.pop_front();
        compare_value($sformatf("pslverr[%02h]", rec.addr), {31'h0, rec.got[32]},
                      {31'h0, rec.exp[32]});
        if (!rec.write) begin
          compare_value($sformatf("prdata[%02h]", rec.addr), rec.got[31:0], rec.exp[31:0]);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (16 + 64 * PLANNED_XFERS) @(posedge clk);
    $display("Timeout: not all APB transfers finished within %0d cycles",
             16 + 64 * PLANNED_XFERS);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation timed out");
  end

  initial begin : main_seq
    logic g1;
    logic g2;
    void'($urandom(32'h70c8));
    reset_n    <= 1'b0;
    m0_paddr   <= '0;
    m0_pwrite  <= 1'b0;
    m0_pwdata  <= '0;
    m0_psel    <= 1'b0;
    m0_penable <= 1'b0;
    m1_paddr   <= '0;
    m1_pwrite  <= 1'b0;
    m1_pwdata  <= '0;
    m1_psel    <= 1'b0;
    m1_penable <= 1'b0;
    gpio1      <= 1'b0;
    gpio2      <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      model_regs[i] = '0;
    end
    model_regs[CTRL_NAME0]   = `TK_NAME0;
    model_regs[CTRL_NAME1]   = `TK_NAME1;
    model_regs[CTRL_VERSION] = `TK_VERSION;
    model_regs[CTRL_LED]     = {29'h0, `TK_LED_RESET};
    model_regs[UDI_FIRST]    = `TK_UDI0;
    model_regs[UDI_LAST]     = `TK_UDI1;
    app_mode_m = 1'b0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;

    // Reset state and identity
    check_pins();
    compare_value("m0_pready", {31'h0, m0_pready}, 32'h0);
    compare_value("m1_pready", {31'h0, m1_pready}, 32'h0);
    xfer_m0(CTRL_NAME0, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_NAME1, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_VERSION, 1'b0, 32'h0, 1'b1);
    xfer_m1(CTRL_VERSION, 1'b0, 32'h0, 1'b1);

    // LED and GPIO
    xfer_m0(CTRL_LED, 1'b1, 32'h1, 1'b1);
    check_pins();
    xfer_m0(CTRL_LED, 1'b0, 32'h0, 1'b1);
    xfer_m1(CTRL_GPIO, 1'b1, 32'hc, 1'b1);
    check_pins();
    xfer_m1(CTRL_GPIO, 1'b1, 32'h4, 1'b1);
    check_pins();
    repeat (4) begin
      g1 = 1'($urandom);
      g2 = 1'($urandom);
      @(posedge clk);
      gpio1 <= g1;
      gpio2 <= g2;
      repeat (4) @(posedge clk);
      model_regs[CTRL_GPIO][1:0] = {g2, g1};
      xfer_m0(CTRL_GPIO, 1'b0, 32'h0, 1'b1);
    end

    // Firmware mode, everything open
    xfer_m0(CTRL_APP_START, 1'b1, $urandom, 1'b1);
    xfer_m0(CTRL_APP_SIZE, 1'b1, $urandom, 1'b1);
    xfer_m1(CTRL_HASH_ADDR, 1'b1, $urandom, 1'b1);
    xfer_m1(CTRL_APP_START, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_APP_SIZE, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_HASH_ADDR, 1'b0, 32'h0, 1'b1);
    for (int i = 0; i < 8; i++) begin
      xfer_m1(CDI_FIRST + 8'(i), 1'b1, $urandom, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      xfer_m0(CDI_FIRST + 8'(i), 1'b0, 32'h0, 1'b1);
    end
    xfer_m1(UDI_FIRST, 1'b0, 32'h0, 1'b1);
    xfer_m1(UDI_LAST, 1'b0, 32'h0, 1'b1);
    xfer_m1(UDI_FIRST, 1'b1, $urandom, 1'b1);
    random_traffic(RAND_OPS);
    check_pins();

    // Application mode locks
    xfer_m0(CTRL_SWITCH_APP, 1'b1, 32'h1, 1'b1);
    check_pins();
    xfer_m0(CTRL_SWITCH_APP, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_APP_START, 1'b1, $urandom, 1'b1);
    xfer_m1(CTRL_APP_SIZE, 1'b1, $urandom, 1'b1);
    xfer_m0(CTRL_HASH_ADDR, 1'b1, $urandom, 1'b1);
    xfer_m1(CDI_FIRST + 8'd3, 1'b1, $urandom, 1'b1);
    xfer_m1(CTRL_APP_START, 1'b0, 32'h0, 1'b1);
    xfer_m0(CTRL_APP_SIZE, 1'b0, 32'h0, 1'b1);
    xfer_m1(CTRL_HASH_ADDR, 1'b0, 32'h0, 1'b1);
    xfer_m0(CDI_FIRST + 8'd3, 1'b0, 32'h0, 1'b1);
    xfer_m0(UDI_FIRST, 1'b0, 32'h0, 1'b1);
    xfer_m1(UDI_LAST, 1'b0, 32'h0, 1'b1);
    xfer_m1(CTRL_LED, 1'b1, 32'h5, 1'b1);
    check_pins();
    random_traffic(RAND_OPS);
    check_pins();

    // Outside both regions
    xfer_m0(8'h40, 1'b0, 32'h0, 1'b1);
    xfer_m1(8'hff, 1'b0, 32'h0, 1'b1);
    xfer_m0(8'h80, 1'b1, $urandom, 1'b1);
    xfer_m1(8'hc3, 1'b1, $urandom, 1'b1);
    repeat (2) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
